//--- ucie_phy_pkg.sv
package ucie_phy_pkg;

  // Field widths
  localparam int SB_MSG_W    = 4;
  localparam int RDI_STATE_W = 4;
  localparam int DWELL_W     = 2;

  typedef logic [SB_MSG_W-1:0]    sb_msg_t;
  typedef logic [RDI_STATE_W-1:0] rdi_state_t;
  typedef logic [DWELL_W-1:0]     dwell_cnt_t;

  // Sideband message codes, held as a level by the sender
  localparam sb_msg_t SB_IDLE       = 4'h0;
  localparam sb_msg_t SB_ACT_REQ    = 4'h1;
  localparam sb_msg_t SB_ACT_RSP    = 4'h2;
  localparam sb_msg_t SB_LNKERR_REQ = 4'h5;
  localparam sb_msg_t SB_LNKERR_RSP = 4'h6;
  localparam sb_msg_t SB_LNKRST_REQ = 4'h7;
  localparam sb_msg_t SB_LNKRST_RSP = 4'h8;

  // RDI state codes, shared by lp_state_req and pl_state_sts
  localparam rdi_state_t RDI_RESET     = 4'd0;
  localparam rdi_state_t RDI_ACTIVE    = 4'd1;
  localparam rdi_state_t RDI_LINKRESET = 4'd9;
  localparam rdi_state_t RDI_LINKERROR = 4'd10;

  // Last dwell count of training and of the partner-event timeout
  localparam dwell_cnt_t TRAIN_LAST   = 2'd3;
  localparam dwell_cnt_t TIMEOUT_LAST = 2'd3;

  typedef enum logic [3:0] {
    GLOBAL_RESET     = 4'd0,
    RESET            = 4'd1,
    LINK_TRAINING    = 4'd2,
    WAIT_FOR_ADAPTER = 4'd3,
    REQ_ACTIVE       = 4'd4,
    RSP_ACTIVE       = 4'd5,
    ACTIVE           = 4'd6,
    LINK_ERR_TX      = 4'd7,
    LINK_RST_TX      = 4'd8,
    LINK_RESET       = 4'd9,
    LINK_ERROR       = 4'd10
  } link_state_e;

  // Decoded adapter request plus local cause flags
  typedef struct packed {
    logic active_req;
    logic active_edge;
    logic linkreset_req;
    logic local_err;
    logic local_rst;
  } rdi_req_s;

  typedef struct packed {
    rdi_state_t pl_state_sts;
    logic       enable;
    logic       inband_pres;
    logic       phyinrecenter;
    logic       train_notify;
    sb_msg_t    sb_msg_out;
  } rdi_status_s;

endpackage

//--- rdi_req_tracker.sv
module rdi_req_tracker (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  ucie_phy_pkg::rdi_state_t i_lp_state_req,
  input  logic                     i_lp_linkerror,
  input  logic                     i_phy_trainerror,
  input  ucie_phy_pkg::link_state_e i_state,
  output ucie_phy_pkg::rdi_req_s   o_req
);

  import ucie_phy_pkg::*;

  rdi_state_t r_prev_req;
  logic       r_local_err;
  logic       r_local_rst;
  logic       w_err;
  logic       w_active_req;
  logic       w_linkreset_req;

  assign w_err           = i_lp_linkerror | i_phy_trainerror;
  assign w_active_req    = (i_lp_state_req == RDI_ACTIVE);
  assign w_linkreset_req = (i_lp_state_req == RDI_LINKRESET);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_prev_req  <= RDI_RESET;
      r_local_err <= 1'b0;
      r_local_rst <= 1'b0;
    end else begin
      r_prev_req <= i_lp_state_req;
      // Active retires old causes and keeps only one raised right now
      if (i_state == ACTIVE) begin
        r_local_err <= w_err;
        r_local_rst <= w_linkreset_req & ~w_err;
      end else if (w_err) begin
        r_local_err <= 1'b1;
      end else if (w_linkreset_req) begin
        r_local_rst <= 1'b1;
      end
    end
  end

  always_comb begin
    o_req.active_req    = w_active_req;
    // Reset to Active transition of the request
    o_req.active_edge   = w_active_req & (r_prev_req == RDI_RESET);
    o_req.linkreset_req = w_linkreset_req;
    o_req.local_err     = r_local_err;
    o_req.local_rst     = r_local_rst;
  end

endmodule

//--- phy_link_timer.sv
module phy_link_timer (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  ucie_phy_pkg::link_state_e i_state,
  output logic                      o_train_done,
  output logic                      o_timeout_done
);

  import ucie_phy_pkg::*;

  link_state_e r_prev_state;
  dwell_cnt_t  r_cnt;
  dwell_cnt_t  w_cnt;
  logic        w_in_timeout;

  // Count restarts at zero on the first cycle of a new state
  assign w_cnt = (i_state != r_prev_state) ? '0 : r_cnt;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_prev_state <= GLOBAL_RESET;
      r_cnt        <= '0;
    end else begin
      r_prev_state <= i_state;
      r_cnt        <= w_cnt + 1'b1;
    end
  end

  assign w_in_timeout = (i_state == LINK_RESET) || (i_state == LINK_ERROR);

  assign o_train_done   = (i_state == LINK_TRAINING) && (w_cnt == TRAIN_LAST);
  assign o_timeout_done = w_in_timeout && (w_cnt == TIMEOUT_LAST);

endmodule

//--- phy_link_fsm.sv
module phy_link_fsm (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  ucie_phy_pkg::rdi_req_s     i_req,
  input  logic                       i_lp_linkerror,
  input  logic                       i_phy_trainerror,
  input  ucie_phy_pkg::sb_msg_t      i_sb_msg_in,
  input  logic                       i_start_training,
  input  logic                       i_train_notify_in,
  input  logic                       i_train_done,
  input  logic                       i_timeout_done,
  output ucie_phy_pkg::link_state_e  o_state
);

  import ucie_phy_pkg::*;

  link_state_e r_state;
  link_state_e w_next_state;
  link_state_e w_abort_state;
  logic        w_abort;
  logic        w_err;
  logic        w_any_flag;

  assign w_err      = i_lp_linkerror | i_phy_trainerror;
  assign w_any_flag = i_req.local_err | i_req.local_rst;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state <= GLOBAL_RESET;
    end else begin
      r_state <= w_next_state;
    end
  end

  // Error and reset entry shared by the abort group, error ranked first
  always_comb begin
    w_abort       = 1'b1;
    w_abort_state = r_state;
    if (w_err) begin
      w_abort_state = LINK_ERR_TX;
    end else if (i_sb_msg_in == SB_LNKERR_REQ) begin
      w_abort_state = LINK_ERROR;
    end else if (i_req.linkreset_req && (r_state != LINK_RESET)) begin
      w_abort_state = LINK_RST_TX;
    end else if ((i_sb_msg_in == SB_LNKRST_REQ) && (r_state != LINK_RESET)) begin
      w_abort_state = LINK_RESET;
    end else begin
      w_abort = 1'b0;
    end
  end

  always_comb begin
    w_next_state = r_state;
    case (r_state)
      GLOBAL_RESET: begin
        w_next_state = LINK_TRAINING;
      end

      RESET: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end else if (i_start_training || i_train_notify_in ||
                     (i_req.active_edge && w_any_flag)) begin
          w_next_state = LINK_TRAINING;
        end
      end

      LINK_TRAINING: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end else if (i_train_done) begin
          w_next_state = WAIT_FOR_ADAPTER;
        end
      end

      WAIT_FOR_ADAPTER: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end else if ((i_sb_msg_in == SB_ACT_REQ) && w_any_flag) begin
          // Recovery after a local event skips the handshake
          w_next_state = ACTIVE;
        end else if (i_sb_msg_in == SB_ACT_REQ) begin
          w_next_state = RSP_ACTIVE;
        end else if (i_req.active_req) begin
          w_next_state = REQ_ACTIVE;
        end
      end

      REQ_ACTIVE: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end else if (i_sb_msg_in == SB_ACT_RSP) begin
          w_next_state = ACTIVE;
        end else if (i_sb_msg_in == SB_ACT_REQ) begin
          w_next_state = RSP_ACTIVE;
        end
      end

      RSP_ACTIVE: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end else if (i_req.active_req) begin
          w_next_state = ACTIVE;
        end
      end

      ACTIVE: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end
      end

      LINK_ERR_TX: begin
        if ((i_sb_msg_in == SB_LNKERR_RSP) || (i_sb_msg_in == SB_LNKERR_REQ)) begin
          w_next_state = LINK_ERROR;
        end
      end

      LINK_RST_TX: begin
        if (i_sb_msg_in == SB_LNKERR_RSP) begin
          w_next_state = LINK_ERROR;
        end else if (i_sb_msg_in == SB_LNKRST_RSP) begin
          w_next_state = LINK_RESET;
        end
      end

      LINK_RESET: begin
        if (w_abort) begin
          w_next_state = w_abort_state;
        end else if ((i_req.local_rst && i_req.active_req) ||
                     (!i_req.local_rst && i_timeout_done)) begin
          w_next_state = RESET;
        end
      end

      LINK_ERROR: begin
        // Local cause waits for the adapter, partner cause times out
        if ((i_req.local_err && i_req.active_req) ||
            (!i_req.local_err && i_timeout_done)) begin
          w_next_state = RESET;
        end
      end

      default: begin
        w_next_state = RESET;
      end
    endcase
  end

  assign o_state = r_state;

endmodule

//--- rdi_status_encode.sv
module rdi_status_encode (
  input  ucie_phy_pkg::link_state_e i_state,
  output ucie_phy_pkg::rdi_status_s o_status
);

  import ucie_phy_pkg::*;

  always_comb begin
    o_status.pl_state_sts  = RDI_RESET;
    o_status.enable        = 1'b0;
    o_status.inband_pres   = 1'b0;
    o_status.phyinrecenter = 1'b0;
    o_status.train_notify  = 1'b0;
    o_status.sb_msg_out    = SB_IDLE;

    case (i_state)
      GLOBAL_RESET, RESET: begin
        o_status.pl_state_sts = RDI_RESET;
      end

      LINK_TRAINING: begin
        o_status.phyinrecenter = 1'b1;
        // Tells the partner die to start training too
        o_status.train_notify  = 1'b1;
      end

      WAIT_FOR_ADAPTER, RSP_ACTIVE: begin
        o_status.inband_pres = 1'b1;
      end

      REQ_ACTIVE: begin
        o_status.inband_pres = 1'b1;
        o_status.sb_msg_out  = SB_ACT_REQ;
      end

      ACTIVE: begin
        o_status.pl_state_sts = RDI_ACTIVE;
        o_status.enable       = 1'b1;
        o_status.inband_pres  = 1'b1;
        o_status.sb_msg_out   = SB_ACT_RSP;
      end

      // Link stays up while the request is in flight
      LINK_ERR_TX: begin
        o_status.pl_state_sts = RDI_ACTIVE;
        o_status.enable       = 1'b1;
        o_status.sb_msg_out   = SB_LNKERR_REQ;
      end

      LINK_RST_TX: begin
        o_status.pl_state_sts = RDI_ACTIVE;
        o_status.enable       = 1'b1;
        o_status.sb_msg_out   = SB_LNKRST_REQ;
      end

      LINK_RESET: begin
        o_status.pl_state_sts = RDI_LINKRESET;
        o_status.sb_msg_out   = SB_LNKRST_RSP;
      end

      LINK_ERROR: begin
        o_status.pl_state_sts = RDI_LINKERROR;
        o_status.sb_msg_out   = SB_LNKERR_RSP;
      end

      default: begin
        o_status.pl_state_sts = RDI_RESET;
      end
    endcase
  end

endmodule

//--- ucie_phy_top.sv
module ucie_phy_top (
  input  logic                     i_clk,
  input  logic                     i_rst_n,

  // Adapter side of RDI
  input  ucie_phy_pkg::rdi_state_t i_rdi_lp_state_req,
  input  logic                     i_rdi_lp_linkerror,

  // PHY and CSR
  input  logic                     i_phy_trainerror,
  input  logic                     i_start_training,

  // Partner die
  input  ucie_phy_pkg::sb_msg_t    i_sb_msg_in,
  input  logic                     i_train_notify_in,

  output ucie_phy_pkg::rdi_state_t o_rdi_pl_state_sts,
  output logic                     o_rdi_enable,
  output logic                     o_rdi_pl_inband_pres,
  output logic                     o_rdi_pl_phyinrecenter,
  output ucie_phy_pkg::sb_msg_t    o_sb_msg_out,
  output logic                     o_train_notify_out
);

  import ucie_phy_pkg::*;

  rdi_req_s    w_req;
  link_state_e w_state;
  logic        w_train_done;
  logic        w_timeout_done;
  rdi_status_s w_status;

  rdi_req_tracker u_tracker (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_lp_state_req   (i_rdi_lp_state_req),
    .i_lp_linkerror   (i_rdi_lp_linkerror),
    .i_phy_trainerror (i_phy_trainerror),
    .i_state          (w_state),
    .o_req            (w_req)
  );

  phy_link_timer u_timer (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_state        (w_state),
    .o_train_done   (w_train_done),
    .o_timeout_done (w_timeout_done)
  );

  phy_link_fsm u_fsm (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_req             (w_req),
    .i_lp_linkerror    (i_rdi_lp_linkerror),
    .i_phy_trainerror  (i_phy_trainerror),
    .i_sb_msg_in       (i_sb_msg_in),
    .i_start_training  (i_start_training),
    .i_train_notify_in (i_train_notify_in),
    .i_train_done      (w_train_done),
    .i_timeout_done    (w_timeout_done),
    .o_state           (w_state)
  );

  rdi_status_encode u_encode (
    .i_state  (w_state),
    .o_status (w_status)
  );

  assign o_rdi_pl_state_sts     = w_status.pl_state_sts;
  assign o_rdi_enable           = w_status.enable;
  assign o_rdi_pl_inband_pres   = w_status.inband_pres;
  assign o_rdi_pl_phyinrecenter = w_status.phyinrecenter;
  assign o_sb_msg_out           = w_status.sb_msg_out;
  assign o_train_notify_out     = w_status.train_notify;

endmodule

//--- tb_link_model.sv
module tb_link_model (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  ucie_phy_pkg::rdi_state_t  i_req,
  input  logic                      i_linkerror,
  input  logic                      i_trainerror,
  input  ucie_phy_pkg::sb_msg_t     i_sb_in,
  input  logic                      i_start,
  input  logic                      i_notify_in,
  output ucie_phy_pkg::rdi_state_t  o_sts,
  output logic                      o_enable,
  output logic                      o_inband,
  output logic                      o_recenter,
  output logic                      o_notify,
  output ucie_phy_pkg::sb_msg_t     o_sb_out
);

  import ucie_phy_pkg::*;

  link_state_e st;
  link_state_e nxt;
  rdi_state_t  prev_req;
  logic        ferr;
  logic        frst;
  int          stay;
  logic        err;
  logic        act;
  logic        edge_act;
  logic        flag;

  always_comb begin
    err      = i_linkerror | i_trainerror;
    act      = (i_req == RDI_ACTIVE);
    edge_act = act && (prev_req == RDI_RESET);
    flag     = ferr | frst;
    nxt      = st;
    if (st == GLOBAL_RESET) nxt = LINK_TRAINING;
    else if (st == LINK_ERR_TX) begin
      if (i_sb_in == SB_LNKERR_RSP || i_sb_in == SB_LNKERR_REQ) nxt = LINK_ERROR;
    end else if (st == LINK_RST_TX) begin
      if (i_sb_in == SB_LNKERR_RSP) nxt = LINK_ERROR;
      else if (i_sb_in == SB_LNKRST_RSP) nxt = LINK_RESET;
    end else if (st == LINK_ERROR) begin
      if ((ferr && act) || (!ferr && stay == 3)) nxt = RESET;
    end else if (err) nxt = LINK_ERR_TX;
    else if (i_sb_in == SB_LNKERR_REQ) nxt = LINK_ERROR;
    else if (st != LINK_RESET && i_req == RDI_LINKRESET) nxt = LINK_RST_TX;
    else if (st != LINK_RESET && i_sb_in == SB_LNKRST_REQ) nxt = LINK_RESET;
    else begin
      case (st)
        RESET: if (i_start || i_notify_in || (edge_act && flag)) nxt = LINK_TRAINING;
        LINK_TRAINING: if (stay == 3) nxt = WAIT_FOR_ADAPTER;
        WAIT_FOR_ADAPTER: begin
          if (i_sb_in == SB_ACT_REQ) nxt = flag ? ACTIVE : RSP_ACTIVE;
          else if (act) nxt = REQ_ACTIVE;
        end
        REQ_ACTIVE: begin
          if (i_sb_in == SB_ACT_RSP) nxt = ACTIVE;
          else if (i_sb_in == SB_ACT_REQ) nxt = RSP_ACTIVE;
        end
        RSP_ACTIVE: if (act) nxt = ACTIVE;
        LINK_RESET: if ((frst && act) || (!frst && stay == 3)) nxt = RESET;
        default: nxt = st;
      endcase
    end
  end

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      st       <= GLOBAL_RESET;
      prev_req <= RDI_RESET;
      ferr     <= 1'b0;
      frst     <= 1'b0;
      stay     <= 0;
    end else begin
      st       <= nxt;
      prev_req <= i_req;
      stay     <= (nxt != st) ? 0 : stay + 1;
      if (st == ACTIVE) begin
        ferr <= err;
        frst <= (i_req == RDI_LINKRESET) && !err;
      end else if (err) ferr <= 1'b1;
      else if (i_req == RDI_LINKRESET) frst <= 1'b1;
    end
  end

  // Expected RDI and sideband outputs per state
  assign o_sts = (st == LINK_RESET) ? RDI_LINKRESET :
                 (st == LINK_ERROR) ? RDI_LINKERROR :
                 (st == ACTIVE || st == LINK_ERR_TX || st == LINK_RST_TX) ? RDI_ACTIVE :
                 RDI_RESET;
  assign o_enable   = (st == ACTIVE || st == LINK_ERR_TX || st == LINK_RST_TX);
  assign o_inband   = (st == WAIT_FOR_ADAPTER || st == RSP_ACTIVE ||
                       st == REQ_ACTIVE || st == ACTIVE);
  assign o_recenter = (st == LINK_TRAINING);
  assign o_notify   = (st == LINK_TRAINING);
  assign o_sb_out   = (st == REQ_ACTIVE)  ? SB_ACT_REQ :
                      (st == ACTIVE)      ? SB_ACT_RSP :
                      (st == LINK_ERR_TX) ? SB_LNKERR_REQ :
                      (st == LINK_RST_TX) ? SB_LNKRST_REQ :
                      (st == LINK_RESET)  ? SB_LNKRST_RSP :
                      (st == LINK_ERROR)  ? SB_LNKERR_RSP : SB_IDLE;

endmodule

//--- tb_ucie_phy.sv
module tb_ucie_phy;

  import ucie_phy_pkg::*;

  localparam int RAND_CYCLES = 4000;
  localparam int TEST_CYCLES = RAND_CYCLES + 600;

  logic i_clk, i_rst_n, i_rdi_lp_linkerror, i_phy_trainerror;
  logic i_train_notify_in, i_start_training;
  rdi_state_t i_rdi_lp_state_req, o_rdi_pl_state_sts, e_sts;
  sb_msg_t i_sb_msg_in, o_sb_msg_out, e_sb;
  logic o_rdi_enable, o_rdi_pl_inband_pres, o_rdi_pl_phyinrecenter, o_train_notify_out;
  logic e_en, e_inband, e_recenter, e_notify;
  logic [31:0] rng;
  int errors, checks, test_err;

  ucie_phy_top dut (.*);

  tb_link_model model (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(i_rdi_lp_state_req),
    .i_linkerror(i_rdi_lp_linkerror), .i_trainerror(i_phy_trainerror),
    .i_sb_in(i_sb_msg_in), .i_start(i_start_training), .i_notify_in(i_train_notify_in),
    .o_sts(e_sts), .o_enable(e_en), .o_inband(e_inband), .o_recenter(e_recenter),
    .o_notify(e_notify), .o_sb_out(e_sb)
  );

  always #10 i_clk = ~i_clk;

  function automatic logic [15:0] next_rand();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng[31:16];
  endfunction

  task automatic compare(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic int pick(input int sel);
    case (sel)
      0: return o_rdi_pl_state_sts;
      1: return o_sb_msg_out;
      2: return o_rdi_pl_inband_pres;
      3: return o_rdi_enable;
      default: return o_train_notify_out;
    endcase
  endfunction

  // Cycle-by-cycle comparison against the model
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      compare("pl_state_sts", o_rdi_pl_state_sts, e_sts);
      compare("enable", o_rdi_enable, e_en);
      compare("inband_pres", o_rdi_pl_inband_pres, e_inband);
      compare("phyinrecenter", o_rdi_pl_phyinrecenter, e_recenter);
      compare("train_notify", o_train_notify_out, e_notify);
      compare("sb_msg_out", o_sb_msg_out, e_sb);
    end
  end

  task automatic wait_out(input int sel, input int val);
    int n;
    n = 0;
    @(negedge i_clk);
    while (pick(sel) != val && n < 40) begin
      n++;
      @(negedge i_clk);
    end
    if (n >= 40) begin
      errors++;
      $display("Output %0d never reached %0h at time %0t", sel, val, $time);
    end
  endtask

  // Cycles an output keeps a value, counted from a negedge where it holds
  task automatic count_while(input int sel, input int val, output int n);
    n = 1;
    @(negedge i_clk);
    while (pick(sel) == val && n < 40) begin
      n++;
      @(negedge i_clk);
    end
  endtask

  task automatic hold_check(input int sel, input int val, input int cycles);
    repeat (cycles) begin
      @(negedge i_clk);
      compare("held output", pick(sel), val);
    end
  endtask

  task automatic drive(input rdi_state_t req, input sb_msg_t sb);
    @(posedge i_clk);
    i_rdi_lp_state_req <= req;
    i_sb_msg_in        <= sb;
  endtask

  task automatic train_to_wait();
    @(posedge i_clk);
    i_start_training <= 1'b1;
    @(posedge i_clk);
    i_start_training <= 1'b0;
    wait_out(2, 1);
  endtask

  task automatic go_active();
    drive(RDI_ACTIVE, SB_IDLE);
    wait_out(1, SB_ACT_REQ);
    drive(RDI_ACTIVE, SB_ACT_RSP);
    wait_out(0, RDI_ACTIVE);
    compare("enable in Active", o_rdi_enable, 1);
  endtask

  task automatic end_test(input string name);
    $display("%s: %s", name, (errors == test_err) ? "passed" : "failed");
    test_err = errors;
  endtask

  // Local cause leaves on the adapter Active request, partner cause times out
  task automatic event_flow(input string name, input sb_msg_t rsp, input rdi_state_t sts,
                            input sb_msg_t partner_req);
    int n;
    train_to_wait();
    go_active();
    if (sts == RDI_LINKERROR) begin
      @(posedge i_clk);
      i_rdi_lp_linkerror <= 1'b1;
      i_rdi_lp_state_req <= RDI_RESET;
      @(posedge i_clk);
      i_rdi_lp_linkerror <= 1'b0;
      wait_out(1, SB_LNKERR_REQ);
    end else begin
      drive(RDI_LINKRESET, SB_IDLE);
      wait_out(1, SB_LNKRST_REQ);
      drive(RDI_RESET, SB_IDLE);
    end
    drive(RDI_RESET, rsp);
    wait_out(0, sts);
    drive(RDI_RESET, SB_IDLE);
    hold_check(0, sts, 6);
    drive(RDI_ACTIVE, SB_IDLE);
    wait_out(0, RDI_RESET);
    drive(RDI_RESET, SB_IDLE);
    train_to_wait();
    go_active();
    drive(RDI_RESET, partner_req);
    wait_out(0, sts);
    drive(RDI_RESET, SB_IDLE);
    count_while(0, sts, n);
    compare("partner event cycles", n, 4);
    end_test(name);
  endtask

  initial begin
    int n;
    logic [15:0] a, b;
    i_clk = 0;
    i_rst_n = 0;
    i_rdi_lp_state_req = RDI_RESET;
    i_rdi_lp_linkerror = 0;
    i_phy_trainerror = 0;
    i_sb_msg_in = SB_IDLE;
    i_train_notify_in = 0;
    i_start_training = 0;
    rng = 32'd80214;
    errors = 0;
    checks = 0;
    test_err = 0;
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;

    wait_out(4, 1);
    count_while(4, 1, n);
    compare("training cycles", n, 4);
    compare("inband_pres after training", o_rdi_pl_inband_pres, 1);
    hold_check(2, 1, 6);
    end_test("bring-up");

    go_active();
    drive(RDI_RESET, SB_LNKRST_REQ);
    wait_out(0, RDI_LINKRESET);
    drive(RDI_RESET, SB_IDLE);
    wait_out(0, RDI_RESET);
    train_to_wait();
    drive(RDI_RESET, SB_ACT_REQ);
    hold_check(0, RDI_RESET, 3);
    drive(RDI_ACTIVE, SB_IDLE);
    wait_out(0, RDI_ACTIVE);
    drive(RDI_RESET, SB_IDLE);
    hold_check(0, RDI_ACTIVE, 3);
    end_test("active");

    drive(RDI_RESET, SB_LNKRST_REQ);
    wait_out(0, RDI_LINKRESET);
    drive(RDI_RESET, SB_IDLE);
    wait_out(0, RDI_RESET);
    event_flow("link error", SB_LNKERR_RSP, RDI_LINKERROR, SB_LNKERR_REQ);
    wait_out(0, RDI_RESET);
    event_flow("link reset", SB_LNKRST_RSP, RDI_LINKRESET, SB_LNKRST_REQ);

    repeat (RAND_CYCLES) begin
      @(posedge i_clk);
      a = next_rand();
      b = next_rand();
      case (a[1:0])
        2'd0: i_rdi_lp_state_req <= RDI_RESET;
        2'd1: i_rdi_lp_state_req <= RDI_ACTIVE;
        2'd2: i_rdi_lp_state_req <= RDI_LINKRESET;
        default: i_rdi_lp_state_req <= a[5:2];
      endcase
      case (a[8:6])
        3'd0: i_sb_msg_in <= SB_IDLE;
        3'd1: i_sb_msg_in <= SB_ACT_REQ;
        3'd2: i_sb_msg_in <= SB_ACT_RSP;
        3'd3: i_sb_msg_in <= SB_LNKERR_REQ;
        3'd4: i_sb_msg_in <= SB_LNKERR_RSP;
        3'd5: i_sb_msg_in <= SB_LNKRST_REQ;
        3'd6: i_sb_msg_in <= SB_LNKRST_RSP;
        default: i_sb_msg_in <= a[12:9];
      endcase
      i_rdi_lp_linkerror <= (b[4:0] == 5'd0);
      i_phy_trainerror   <= (b[9:5] == 5'd0);
      i_start_training   <= (b[12:10] == 3'd0);
      i_train_notify_in  <= (b[15:13] == 3'd0);
    end
    @(negedge i_clk);
    end_test("random mix");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 20 + 2000);
    $display("Watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- list.f
ucie_phy_pkg.sv
rdi_req_tracker.sv
phy_link_timer.sv
phy_link_fsm.sv
rdi_status_encode.sv
ucie_phy_top.sv
tb_link_model.sv
tb_ucie_phy.sv

//--- Makefile
.PHONY: all lint clean

TOP := tb_ucie_phy

all:
	verilator --binary --timing -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)
	verilator --lint-only -Wall -f list.f --top-module ucie_phy_top

clean:
	rm -rf obj_dir
